//--- vlog.f
source/mips_pkg.sv
source/pc_reg.sv
source/id_stage.sv
source/regfile.sv
source/oitf.sv
source/ex_stage.sv
source/mips_core.sv
tests/mips_core_asserts.sv
tests/tb_mips_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mips_core
FILELIST   := vlog.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LOG        := sim.log
FAIL_MSG   := Simulation finished: FAIL
PASS_MSG   := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
	import mips_pkg::*;
();

	localparam int                N_RAND   = 200;
	localparam int                PROG_LEN = N_RAND + 8;
	localparam int                TIMEOUT  = 5000;
	localparam logic [ADDR_W-1:0] RESET_PC = '0;

	logic              clk = 1'b0;
	logic              rst_n_i;
	word_t             rom_data_i;
	logic [ADDR_W-1:0] rom_addr_o;
	logic              rom_ce_o;
	logic [ADDR_W-1:0] mem_addr_o;
	logic              mem_we_o;
	word_t             mem_data_o;
	logic              mem_ce_o;
	word_t             mem_data_i;

	word_t             prog [PROG_LEN];
	word_t             ram [64];
	word_t             read_q;
	word_t             model_regs [32];
	word_t             model_mem [64];
	logic [ADDR_W-1:0] exp_addr [$];
	word_t             exp_data [$];
	logic [ADDR_W-1:0] exp_a;
	word_t             exp_d;
	logic [ADDR_W-1:0] prev_pc;
	logic              prev_ce;
	integer            seed;
	int                errors;
	int                store_count;
	int                exp_count;

	always #4 clk = ~clk;

	mips_core #(
		.RESET_PC(RESET_PC),
		.OITF_DEPTH(4)
	) dut_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.rom_data_i(rom_data_i), .rom_addr_o(rom_addr_o), .rom_ce_o(rom_ce_o),
		.mem_addr_o(mem_addr_o), .mem_we_o(mem_we_o), .mem_data_o(mem_data_o),
		.mem_ce_o(mem_ce_o), .mem_data_i(mem_data_i)
	);

	bind mips_core mips_core_asserts u_asserts (
		.clk(clk), .rst_n_i(rst_n_i),
		.rom_addr_i(rom_addr_o), .rom_ce_i(rom_ce_o),
		.mem_ce_i(mem_ce_o), .mem_we_i(mem_we_o)
	);

	// past the program the ROM reads zero, a no-op
	assign rom_data_i = (rom_addr_o < ADDR_W'(PROG_LEN * 4)) ? prog[rom_addr_o[9:2]] : '0;

	// sync RAM, a read issued last cycle shows up now
	always @(negedge clk) begin
		mem_data_i = read_q;
		if (mem_ce_o && mem_we_o) begin
			ram[mem_addr_o[7:2]] = mem_data_o;
		end else if (mem_ce_o) begin
			read_q = ram[mem_addr_o[7:2]];
		end
	end

	always @(negedge clk) begin
		if (!rst_n_i) begin
			prev_ce = 1'b0;
		end else begin
			if (prev_ce && rom_addr_o != prev_pc && rom_addr_o != prev_pc + 32'd4) begin
				$display("ERR fetch_order: expected %h or %h, actual %h",
					prev_pc, prev_pc + 32'd4, rom_addr_o);
				errors++;
			end
			prev_ce = rom_ce_o;
			prev_pc = rom_addr_o;
			if (mem_ce_o && mem_addr_o >= 32'd256) begin
				$display("RAM access at %h lies outside the 64-word RAM", mem_addr_o);
				errors++;
			end
			if (mem_ce_o && mem_we_o) begin
				store_count++;
				if (exp_addr.size() == 0) begin
					$display("store to %h when the model expects no more stores", mem_addr_o);
					errors++;
				end else begin
					exp_a = exp_addr.pop_front();
					exp_d = exp_data.pop_front();
					if (mem_addr_o !== exp_a) begin
						$display("ERR store_addr #%0d: expected %h, actual %h",
							store_count, exp_a, mem_addr_o);
						errors++;
					end
					if (mem_data_o !== exp_d) begin
						$display("ERR store_data #%0d: expected %h, actual %h",
							store_count, exp_d, mem_data_o);
						errors++;
					end
				end
			end
		end
	end

	function automatic word_t encode_rtype(logic [5:0] fn, int rs, int rt, int rd);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t encode_itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// registers 0 to 7 only, so hazards are frequent
	task automatic build_program();
		int          kind;
		int          rs;
		int          rt;
		int          rd;
		logic [15:0] imm;
		logic [15:0] off;
		for (int i = 0; i < N_RAND; i++) begin
			kind = $unsigned($random(seed)) % 12;
			rs   = $unsigned($random(seed)) % 8;
			rt   = $unsigned($random(seed)) % 8;
			rd   = $unsigned($random(seed)) % 8;
			imm  = 16'($random(seed));
			off  = {8'h00, 6'($random(seed)), 2'b00};
			case (kind)
				0:       prog[i] = encode_rtype(FN_ADDU, rs, rt, rd);
				1:       prog[i] = encode_rtype(FN_SUBU, rs, rt, rd);
				2:       prog[i] = encode_rtype(FN_AND, rs, rt, rd);
				3:       prog[i] = encode_rtype(FN_OR, rs, rt, rd);
				4:       prog[i] = encode_rtype(FN_XOR, rs, rt, rd);
				5:       prog[i] = encode_rtype(FN_SLT, rs, rt, rd);
				6:       prog[i] = encode_itype(OP_ADDIU, rs, rt, imm);
				7:       prog[i] = encode_itype(OP_ANDI, rs, rt, imm);
				8:       prog[i] = encode_itype(OP_ORI, rs, rt, imm);
				9:       prog[i] = encode_itype(OP_LUI, 0, rt, imm);
				10:      prog[i] = encode_itype(OP_LW, 0, rt, off);
				default: prog[i] = encode_itype(OP_SW, 0, rt, off);
			endcase
		end
		// epilogue dumps $0..$7 to the top eight words
		for (int r = 0; r < 8; r++) begin
			prog[N_RAND + r] = encode_itype(OP_SW, 0, r, 16'(224 + 4 * r));
		end
	endtask

	// sequential ISA reference, one instruction per call
	task automatic model_execute(input word_t inst);
		word_t a;
		word_t b;
		word_t imm_s;
		word_t imm_z;
		word_t addr;
		word_t res;
		int    dest;
		a     = model_regs[inst[25:21]];
		b     = model_regs[inst[20:16]];
		imm_s = {{16{inst[15]}}, inst[15:0]};
		imm_z = {16'h0000, inst[15:0]};
		addr  = a + imm_s;
		res   = '0;
		dest  = 0;
		case (inst[31:26])
			OP_SPECIAL: begin
				dest = inst[15:11];
				case (inst[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: dest = 0;
				endcase
			end
			OP_ADDIU: begin
				dest = inst[20:16];
				res  = a + imm_s;
			end
			OP_ANDI: begin
				dest = inst[20:16];
				res  = a & imm_z;
			end
			OP_ORI: begin
				dest = inst[20:16];
				res  = a | imm_z;
			end
			OP_LUI: begin
				dest = inst[20:16];
				res  = {inst[15:0], 16'h0000};
			end
			OP_LW: begin
				dest = inst[20:16];
				res  = model_mem[addr[7:2]];
			end
			OP_SW: begin
				model_mem[addr[7:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
			end
			default: ;
		endcase
		if (dest != 0) begin
			model_regs[dest] = res;
		end
	endtask

	initial begin
		int   wait_cycles;
		logic timed_out;
		rst_n_i     = 1'b0;
		mem_data_i  = '0;
		read_q      = '0;
		prev_pc     = '0;
		prev_ce     = 1'b0;
		seed        = 32'hd472_82ed;
		errors      = 0;
		store_count = 0;
		timed_out   = 1'b0;
		for (int i = 0; i < 64; i++) begin
			ram[i]       = '0;
			model_mem[i] = '0;
		end
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		build_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			model_execute(prog[i]);
		end
		exp_count = exp_addr.size();

		repeat (2) @(posedge clk);
		@(negedge clk);
		if (rom_ce_o !== 1'b0 || mem_ce_o !== 1'b0 || mem_we_o !== 1'b0) begin
			$display("a strobe is not low while reset is asserted");
			errors++;
		end
		rst_n_i = 1'b1;
		@(negedge clk);
		if (rom_ce_o !== 1'b1) begin
			$display("rom_ce_o did not rise in the first cycle after reset");
			errors++;
		end
		if (rom_addr_o !== RESET_PC) begin
			$display("ERR reset_pc: expected %h, actual %h", RESET_PC, rom_addr_o);
			errors++;
		end

		wait_cycles = 0;
		while (rom_addr_o < ADDR_W'(PROG_LEN * 4) && wait_cycles < TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (wait_cycles >= TIMEOUT) begin
			$display("timeout: fetch never reached the end of the program");
			timed_out = 1'b1;
			errors++;
		end

		wait_cycles = 0;
		while (!timed_out && store_count < exp_count && wait_cycles < TIMEOUT) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!timed_out && wait_cycles >= TIMEOUT) begin
			$display("timeout: the core stopped storing before the epilogue finished");
			errors++;
		end

		// let the last instructions leave the pipeline
		repeat (4) @(negedge clk);
		if (store_count != exp_count) begin
			$display("ERR store_count: expected %0d, actual %0d", exp_count, store_count);
			errors++;
		end

		$display("errors: %0d, stores: %0d of %0d", errors, store_count, exp_count);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/mips_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts
	import mips_pkg::*;
(
	input logic              clk,
	input logic              rst_n_i,
	input logic [ADDR_W-1:0] rom_addr_i,
	input logic              rom_ce_i,
	input logic              mem_ce_i,
	input logic              mem_we_i
);

	// reset was already low at the previous edge
	logic rst_low_q;

	always_ff @(posedge clk) begin
		rst_low_q <= !rst_n_i;
	end

	a_we_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_we_i |-> mem_ce_i)
		else $error("mem_we_o high without mem_ce_o");

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		rom_addr_i[1:0] == 2'b00)
		else $error("rom_addr_o not word aligned");

	a_reset_quiet: assert property (@(posedge clk)
		(rst_low_q && !rst_n_i) |-> (!rom_ce_i && !mem_ce_i && !mem_we_i))
		else $error("strobe active during reset");

	a_pc_step: assert property (@(posedge clk) disable iff (!rst_n_i)
		rom_ce_i |=> (rom_addr_i == $past(rom_addr_i)) ||
			(rom_addr_i == $past(rom_addr_i) + 32'd4))
		else $error("rom_addr_o neither held nor advanced by four");

endmodule

`default_nettype wire

//--- source/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
	parameter logic [mips_pkg::ADDR_W-1:0] RESET_PC   = '0,
	parameter int unsigned                 OITF_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  mips_pkg::word_t             rom_data_i,
	output logic [mips_pkg::ADDR_W-1:0] rom_addr_o,
	output logic                        rom_ce_o,
	output logic [mips_pkg::ADDR_W-1:0] mem_addr_o,
	output logic                        mem_we_o,
	output mips_pkg::word_t             mem_data_o,
	output logic                        mem_ce_o,
	input  mips_pkg::word_t             mem_data_i
);

	logic                stall;
	logic                reg1_read;
	logic                reg2_read;
	mips_pkg::reg_idx_t  reg1_addr;
	mips_pkg::reg_idx_t  reg2_addr;
	mips_pkg::word_t     reg1_data;
	mips_pkg::word_t     reg2_data;
	logic                match1;
	logic                match2;
	logic                oitf_full;
	logic                disp;
	mips_pkg::reg_idx_t  disp_rd;

	// decode to execute
	logic                ex_valid;
	mips_pkg::alu_op_e   ex_aluop;
	mips_pkg::word_t     ex_op1;
	mips_pkg::word_t     ex_op2;
	mips_pkg::word_t     ex_store_data;
	logic                ex_wreg;
	logic                ex_load;
	logic                ex_store;
	mips_pkg::reg_idx_t  ex_wd;

	// execute to write-back
	logic                wb_wreg;
	logic                wb_load;
	mips_pkg::reg_idx_t  wb_wd;
	mips_pkg::word_t     wb_wdata;

	pc_reg #(.RESET_PC(RESET_PC)) u_pc_reg (
		.clk(clk), .rst_n_i(rst_n_i),
		.stall_i(stall),
		.pc_o(rom_addr_o),
		.ce_o(rom_ce_o)
	);

	id_stage u_id_stage (
		.clk(clk), .rst_n_i(rst_n_i),
		.pc_ce_i(rom_ce_o),
		.inst_i(rom_data_i),
		.reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
		.reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
		.reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
		.match1_i(match1), .match2_i(match2), .oitf_full_i(oitf_full),
		.disp_o(disp), .disp_rd_o(disp_rd),
		.stall_o(stall),
		.ex_valid_o(ex_valid), .ex_aluop_o(ex_aluop),
		.ex_op1_o(ex_op1), .ex_op2_o(ex_op2), .ex_store_data_o(ex_store_data),
		.ex_wreg_o(ex_wreg), .ex_load_o(ex_load), .ex_store_o(ex_store),
		.ex_wd_o(ex_wd)
	);

	regfile u_regfile (
		.clk(clk), .rst_n_i(rst_n_i),
		.we_i(wb_wreg), .waddr_i(wb_wd), .wdata_i(wb_wdata),
		.wload_i(wb_load), .mem_data_i(mem_data_i),
		.re1_i(reg1_read), .raddr1_i(reg1_addr), .rdata1_o(reg1_data),
		.re2_i(reg2_read), .raddr2_i(reg2_addr), .rdata2_o(reg2_data)
	);

	// a write-back always retires the oldest entry
	oitf #(.OITF_DEPTH(OITF_DEPTH)) u_oitf (
		.clk(clk), .rst_n_i(rst_n_i),
		.disp_i(disp), .disp_rd_i(disp_rd),
		.ret_i(wb_wreg),
		.rd1_en_i(reg1_read), .rd1_idx_i(reg1_addr),
		.rd2_en_i(reg2_read), .rd2_idx_i(reg2_addr),
		.match1_o(match1), .match2_o(match2),
		.full_o(oitf_full)
	);

	ex_stage u_ex_stage (
		.clk(clk), .rst_n_i(rst_n_i),
		.valid_i(ex_valid), .aluop_i(ex_aluop),
		.op1_i(ex_op1), .op2_i(ex_op2), .store_data_i(ex_store_data),
		.wreg_i(ex_wreg), .load_i(ex_load), .store_i(ex_store),
		.wd_i(ex_wd),
		.mem_ce_o(mem_ce_o), .mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
		.wb_wreg_o(wb_wreg), .wb_load_o(wb_load),
		.wb_wd_o(wb_wd), .wb_wdata_o(wb_wdata)
	);

endmodule

`default_nettype wire

//--- source/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage
	import mips_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  alu_op_e           aluop_i,
	input  word_t             op1_i,
	input  word_t             op2_i,
	input  word_t             store_data_i,
	input  logic              wreg_i,
	input  logic              load_i,
	input  logic              store_i,
	input  reg_idx_t          wd_i,
	output logic              mem_ce_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output word_t             mem_data_o,
	output logic              wb_wreg_o,
	output logic              wb_load_o,
	output reg_idx_t          wb_wd_o,
	output word_t             wb_wdata_o
);

	word_t result;

	// loads and stores use ADD for the byte address
	always_comb begin
		case (aluop_i)
			ADD:     result = op1_i + op2_i;
			SUB:     result = op1_i - op2_i;
			AND:     result = op1_i & op2_i;
			OR:      result = op1_i | op2_i;
			XOR:     result = op1_i ^ op2_i;
			SLT:     result = {{(REG_W-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
			PASS_B:  result = op2_i;
			default: result = '0;
		endcase
	end

	// RAM strobes in the execute cycle, read data returns next cycle
	assign mem_ce_o   = valid_i & (load_i | store_i);
	assign mem_we_o   = valid_i & store_i;
	assign mem_addr_o = ADDR_W'(result);
	assign mem_data_o = store_data_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_wreg_o <= 1'b0;
			wb_load_o <= 1'b0;
		end else begin
			wb_wreg_o <= valid_i & wreg_i;
			wb_load_o <= valid_i & load_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_wd_o    <= wd_i;
		wb_wdata_o <= result;
	end

endmodule

`default_nettype wire

//--- source/oitf.sv
`timescale 1ns/1ps
`default_nettype none

module oitf
	import mips_pkg::*;
#(
	parameter int unsigned OITF_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     disp_i,
	input  reg_idx_t disp_rd_i,
	input  logic     ret_i,
	input  logic     rd1_en_i,
	input  logic     rd2_en_i,
	input  reg_idx_t rd1_idx_i,
	input  reg_idx_t rd2_idx_i,
	output logic     match1_o,
	output logic     match2_o,
	output logic     full_o
);

	localparam int PTR_W = $clog2(OITF_DEPTH);

	logic [PTR_W-1:0]      wptr;
	logic [PTR_W-1:0]      rptr;
	logic [OITF_DEPTH-1:0] vld;
	reg_idx_t              rd_q [OITF_DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wptr <= '0;
			rptr <= '0;
			vld  <= '0;
		end else begin
			// oldest entry leaves first, write-back is in order
			if (ret_i) begin
				vld[rptr] <= 1'b0;
				rptr      <= (rptr == PTR_W'(OITF_DEPTH - 1)) ? '0 : rptr + 1'b1;
			end
			if (disp_i) begin
				vld[wptr] <= 1'b1;
				wptr      <= (wptr == PTR_W'(OITF_DEPTH - 1)) ? '0 : wptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (disp_i) begin
			rd_q[wptr] <= disp_rd_i;
		end
	end

	// slot under wptr still valid means no room left
	assign full_o = vld[wptr];

	always_comb begin
		match1_o = 1'b0;
		match2_o = 1'b0;
		for (int i = 0; i < OITF_DEPTH; i++) begin
			if (vld[i] && rd1_en_i && rd_q[i] == rd1_idx_i) begin
				match1_o = 1'b1;
			end
			if (vld[i] && rd2_en_i && rd_q[i] == rd2_idx_i) begin
				match2_o = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     we_i,
	input  reg_idx_t waddr_i,
	input  word_t    wdata_i,
	input  logic     wload_i,
	input  word_t    mem_data_i,
	input  logic     re1_i,
	input  logic     re2_i,
	input  reg_idx_t raddr1_i,
	input  reg_idx_t raddr2_i,
	output word_t    rdata1_o,
	output word_t    rdata2_o
);

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	word_t regs [NUM_REGS];

	// load data arrives from the RAM in the write-back cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wload_i ? mem_data_i : wdata_i;
		end
	end

	// $0 always reads as zero
	assign rdata1_o = (re1_i && raddr1_i != '0) ? regs[raddr1_i] : '0;
	assign rdata2_o = (re2_i && raddr2_i != '0) ? regs[raddr2_i] : '0;

endmodule

`default_nettype wire

//--- source/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     pc_ce_i,
	input  word_t    inst_i,
	output logic     reg1_read_o,
	output logic     reg2_read_o,
	output reg_idx_t reg1_addr_o,
	output reg_idx_t reg2_addr_o,
	input  word_t    reg1_data_i,
	input  word_t    reg2_data_i,
	input  logic     match1_i,
	input  logic     match2_i,
	input  logic     oitf_full_i,
	output logic     disp_o,
	output reg_idx_t disp_rd_o,
	output logic     stall_o,
	output logic     ex_valid_o,
	output alu_op_e  ex_aluop_o,
	output word_t    ex_op1_o,
	output word_t    ex_op2_o,
	output word_t    ex_store_data_o,
	output logic     ex_wreg_o,
	output logic     ex_load_o,
	output logic     ex_store_o,
	output reg_idx_t ex_wd_o
);

	logic [5:0]  op;
	logic [5:0]  funct;
	logic [15:0] imm;
	word_t       imm_sext;
	word_t       imm_zext;
	logic        r_ok;
	alu_op_e     aluop;
	word_t       op2;
	logic        wreg;
	logic        load;
	logic        store;
	reg_idx_t    wd;

	assign op          = inst_i[31:26];
	assign funct       = inst_i[5:0];
	assign imm         = inst_i[15:0];
	assign imm_sext    = {{(REG_W-16){imm[15]}}, imm};
	assign imm_zext    = {{(REG_W-16){1'b0}}, imm};
	assign reg1_addr_o = inst_i[25:21];
	assign reg2_addr_o = inst_i[20:16];

	always_comb begin
		r_ok        = 1'b0;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		aluop       = ADD;
		op2         = imm_sext;
		wreg        = 1'b0;
		load        = 1'b0;
		store       = 1'b0;
		wd          = inst_i[20:16];
		if (pc_ce_i) begin
			case (op)
				OP_SPECIAL: begin
					r_ok = 1'b1;
					case (funct)
						FN_ADDU: aluop = ADD;
						FN_SUBU: aluop = SUB;
						FN_AND:  aluop = AND;
						FN_OR:   aluop = OR;
						FN_XOR:  aluop = XOR;
						FN_SLT:  aluop = SLT;
						default: r_ok = 1'b0;
					endcase
					reg1_read_o = r_ok;
					reg2_read_o = r_ok;
					op2         = reg2_data_i;
					wreg        = r_ok;
					wd          = inst_i[15:11];
				end
				OP_ADDIU: begin
					reg1_read_o = 1'b1;
					wreg        = 1'b1;
				end
				OP_ANDI, OP_ORI: begin
					reg1_read_o = 1'b1;
					aluop       = (op == OP_ANDI) ? AND : OR;
					op2         = imm_zext;
					wreg        = 1'b1;
				end
				OP_LUI: begin
					aluop = PASS_B;
					op2   = {imm, 16'h0000};
					wreg  = 1'b1;
				end
				OP_LW: begin
					reg1_read_o = 1'b1;
					wreg        = 1'b1;
					load        = 1'b1;
				end
				// rt is read as store data only
				OP_SW: begin
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;
					store       = 1'b1;
				end
				default: ;
			endcase
		end
		if (wd == '0) begin
			wreg = 1'b0;
		end
	end

	assign stall_o   = match1_i | match2_i | (oitf_full_i & wreg);
	assign disp_o    = wreg & ~stall_o;
	assign disp_rd_o = wd;

	// a stalled slot leaves as a bubble
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_valid_o <= 1'b0;
			ex_wreg_o  <= 1'b0;
			ex_load_o  <= 1'b0;
			ex_store_o <= 1'b0;
		end else begin
			ex_valid_o <= pc_ce_i & ~stall_o;
			ex_wreg_o  <= wreg & ~stall_o;
			ex_load_o  <= load & ~stall_o;
			ex_store_o <= store & ~stall_o;
		end
	end

	always_ff @(posedge clk) begin
		ex_aluop_o      <= aluop;
		ex_op1_o        <= reg1_data_i;
		ex_op2_o        <= op2;
		ex_store_data_o <= reg2_data_i;
		ex_wd_o         <= wd;
	end

endmodule

`default_nettype wire

//--- source/pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pc_reg
	import mips_pkg::*;
#(
	parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              stall_i,
	output logic [ADDR_W-1:0] pc_o,
	output logic              ce_o
);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ce_o <= 1'b0;
			pc_o <= RESET_PC;
		end else begin
			// fetch starts one cycle after release, at RESET_PC
			ce_o <= 1'b1;
			if (ce_o && !stall_i) begin
				pc_o <= pc_o + ADDR_W'(4);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int INST_W     = 32;
	localparam int REG_W      = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ADDR_W     = 32;

	typedef logic [REG_W-1:0]      word_t;
	typedef logic [REG_ADDR_W-1:0] reg_idx_t;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// funct field of SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	// PASS_B forwards operand 2 untouched, used by LUI
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		PASS_B
	} alu_op_e;

endpackage

`default_nettype wire
